/* Makefile */
TOP := reg_array_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

obj_dir/V$(TOP): files.f design/*.sv tests/*.sv include/*.svh
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* design/csr_file.sv */
module csr_file import rv_types_pkg::*, csr_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  csr_idx_t   csr_rs,
  input  csr_write_t wr,
  input  logic       ecall,
  input  word_t      ecall_arg,
  output word_t      csra
);

  word_t csrs     [csr_count]; // current CSR contents indexed by csr_idx_t
  word_t csr_next [csr_count]; // contents after the coming edge

  logic mcause_load; // ecall overrides anything aimed at mcause

  assign mcause_load = ecall;

  always_comb begin
    for (int i = 0; i < csr_count; i++) begin
      csr_next[i] = csrs[i];
      if (wr.en && (int'(wr.idx) == i)) begin
        csr_next[i] = wr.data;
      end
    end

    // Writes to mepc, mstatus and mtvec still go through during an ecall
    if (mcause_load) begin
      csr_next[csr_mcause] = ecall_arg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < csr_count; i++) begin
        csrs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < csr_count; i++) begin
        csrs[i] <= csr_next[i];
      end
    end
  end

  // read port shows the stored value, so a same cycle write returns the old one
  assign csra = csrs[csr_rs];

endmodule

/* design/csr_pkg.sv */
`include "regs_settings.svh"

package csr_pkg;

  import rv_types_pkg::*;

  localparam int csr_count = `REGS_CSR_COUNT;

  localparam int csr_idx_w = $clog2(csr_count); // only the low bits of the CSR address

  // compact CSR index; the full 12-bit address is decoded elsewhere
  typedef enum logic [csr_idx_w-1:0] {
    csr_mcause  = 0, // written by ecall as well
    csr_mepc    = 1,
    csr_mstatus = 2,
    csr_mtvec   = 3
  } csr_idx_t;

  // one CSR write from a csrrw style instruction
  typedef struct packed {
    logic     en;   // write this cycle
    csr_idx_t idx;  // target CSR
    word_t    data; // value stored at the next edge
  } csr_write_t;

endpackage

/* design/gpr_file.sv */
`include "regs_settings.svh"

module gpr_file import rv_types_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  gpr_idx_t   rs1,
  input  gpr_idx_t   rs2,
  input  gpr_write_t wr,
  output word_t      rsa,
  output word_t      rsb,
  output word_t      ecall_arg
);

  localparam int stored_count = `REGS_GPR_COUNT - 1; // x0 has no storage

  // storage for x1 to x31, indexed by register number
  word_t regs [1:stored_count];

  logic wr_hit; // a write that actually lands

  // returns the architectural value of one register
  function automatic word_t read_gpr(input gpr_idx_t idx);
    word_t value;
    value = '0; // x0 always reads zero
    if (idx != '0) begin
      value = regs[idx];
    end
    return value;
  endfunction

  assign wr_hit = wr.en && (wr.idx != '0); // writes to x0 are dropped here

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i <= stored_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wr.idx] <= wr.data; // seen on the read ports one cycle later
    end
  end

  // both read ports see the stored contents only, there is no bypass
  always_comb begin
    rsa = read_gpr(rs1);
  end

  always_comb begin
    rsb = read_gpr(rs2);
  end

  // tap of the ecall argument register for the CSR file
  assign ecall_arg = regs[ecall_arg_idx];

endmodule

/* design/reg_array.sv */
module reg_array import rv_types_pkg::*, csr_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  gpr_idx_t   rs1,
  input  gpr_idx_t   rs2,
  input  csr_idx_t   csr_rs,
  input  gpr_write_t gpr_wr,
  input  csr_write_t csr_wr,
  input  logic       ecall,
  output word_t      rsa,
  output word_t      rsb,
  output word_t      csra
);

  word_t ecall_arg; // stored x17 on its way to mcause

  // general-purpose registers x0 to x31
  gpr_file u_gpr (
    .clk       (clk),
    .reset     (reset),
    .rs1       (rs1),
    .rs2       (rs2),
    .wr        (gpr_wr),
    .rsa       (rsa),
    .rsb       (rsb),
    .ecall_arg (ecall_arg)
  );

  // machine CSRs, mcause is also loaded by ecall
  csr_file u_csr (
    .clk       (clk),
    .reset     (reset),
    .csr_rs    (csr_rs),
    .wr        (csr_wr),
    .ecall     (ecall),
    .ecall_arg (ecall_arg),
    .csra      (csra)
  );

endmodule

/* design/rv_types_pkg.sv */
`include "regs_settings.svh"

package rv_types_pkg;

  localparam int xlen = `REGS_XLEN;

  localparam int gpr_count = `REGS_GPR_COUNT;

  localparam int gpr_idx_w = $clog2(gpr_count); // 5 bits address all 32 registers

  // one architectural register value
  typedef logic [xlen-1:0] word_t;

  // register number as it appears in the rs1, rs2 and rd fields
  typedef logic [gpr_idx_w-1:0] gpr_idx_t;

  // the register that ecall copies into mcause, never x0
  localparam gpr_idx_t ecall_arg_idx = gpr_idx_t'(`REGS_ECALL_ARG);

  // one GPR write as the writeback stage presents it
  typedef struct packed {
    logic     en;   // write this cycle
    gpr_idx_t idx;  // destination register
    word_t    data; // value stored at the next edge
  } gpr_write_t;

endpackage

/* files.f */
+incdir+include
design/rv_types_pkg.sv
design/csr_pkg.sv
design/gpr_file.sv
design/csr_file.sv
design/reg_array.sv
tests/reg_array_asserts.sv
tests/reg_array_checker.sv
tests/reg_array_tb.sv

/* include/regs_settings.svh */
`ifndef REGS_SETTINGS_SVH
`define REGS_SETTINGS_SVH

// sizes of the architectural register block

`define REGS_XLEN 32 // width of every GPR and CSR

`define REGS_GPR_COUNT 32 // x0 to x31 with x0 hard-wired to zero

`define REGS_CSR_COUNT 4 // mcause, mepc, mstatus and mtvec

// ecall passes its cause in a7, which is register x17
`define REGS_ECALL_ARG 17

`endif

/* tests/reg_array_asserts.sv */
module reg_array_asserts import rv_types_pkg::*, csr_pkg::*; (
  input logic     clk,
  input logic     reset,
  input gpr_idx_t rs1,
  input gpr_idx_t rs2,
  input csr_idx_t csr_rs,
  input logic     ecall,
  input word_t    ecall_arg,
  input word_t    rsa,
  input word_t    rsb,
  input word_t    csra
);

  x0_on_rsa: assert property (@(posedge clk) disable iff (reset)
    (rs1 == '0) |-> (rsa == '0))
    else $error("rsa is not zero while reading x0");

  x0_on_rsb: assert property (@(posedge clk) disable iff (reset)
    (rs2 == '0) |-> (rsb == '0))
    else $error("rsb is not zero while reading x0");

  // the first cycle out of reset sees cleared storage on every port
  clear_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> ((rsa == '0) && (rsb == '0) && (csra == '0)))
    else $error("a read port is not zero in the cycle after reset");

  ecall_loads_mcause: assert property (@(posedge clk) disable iff (reset)
    ecall |=> ((csr_rs != csr_mcause) || (csra == $past(ecall_arg))))
    else $error("mcause does not hold the previous x17 after ecall");

endmodule

bind reg_array reg_array_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .rs1       (rs1),
  .rs2       (rs2),
  .csr_rs    (csr_rs),
  .ecall     (ecall),
  .ecall_arg (ecall_arg),
  .rsa       (rsa),
  .rsb       (rsb),
  .csra      (csra)
);

/* tests/reg_array_checker.sv */
module reg_array_checker import rv_types_pkg::*, csr_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  gpr_idx_t   rs1,
  input  gpr_idx_t   rs2,
  input  csr_idx_t   csr_rs,
  input  gpr_write_t gpr_wr,
  input  csr_write_t csr_wr,
  input  logic       ecall,
  input  word_t      rsa,
  input  word_t      rsb,
  input  word_t      csra,
  output int         check_count,
  output int         error_count
);

  word_t gpr_shadow [gpr_count]; // entry 0 is never written
  word_t csr_shadow [csr_count];

  // expected value of a GPR, or of a CSR when is_csr is set
  function automatic word_t expected_value(input logic is_csr, input gpr_idx_t idx);
    word_t value;
    if (is_csr) begin
      value = csr_shadow[idx[csr_idx_w-1:0]];
    end else if (idx == '0) begin
      value = '0;
    end else begin
      value = gpr_shadow[idx];
    end
    return value;
  endfunction

  function automatic int port_mismatch(
    input string name,
    input int    idx,
    input word_t expected,
    input word_t actual
  );
    int bad;
    bad = 0;
    if (actual !== expected) begin
      $display("error %s (index %0d) at time %0t: expected %h, got %h",
               name, idx, $time, expected, actual);
      bad = 1;
    end
    return bad;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < gpr_count; i++) begin
        gpr_shadow[i] <= '0;
      end
      for (int i = 0; i < csr_count; i++) begin
        csr_shadow[i] <= '0;
      end
    end else begin
      if (gpr_wr.en && (gpr_wr.idx != '0)) begin
        gpr_shadow[gpr_wr.idx] <= gpr_wr.data;
      end
      if (csr_wr.en && !(ecall && (csr_wr.idx == csr_mcause))) begin
        csr_shadow[csr_wr.idx] <= csr_wr.data;
      end
      if (ecall) begin
        csr_shadow[csr_mcause] <= gpr_shadow[ecall_arg_idx]; // x17 as it was before this edge
      end
    end
  end

  // outputs are settled half a period after the inputs change
  always @(negedge clk) begin : compare
    int bad;
    bad = 0;
    if (!reset) begin
      bad += port_mismatch("rsa", int'(rs1), expected_value(1'b0, rs1), rsa);
      bad += port_mismatch("rsb", int'(rs2), expected_value(1'b0, rs2), rsb);
      bad += port_mismatch("csra", int'(csr_rs), expected_value(1'b1, gpr_idx_t'(csr_rs)), csra);
      check_count <= check_count + 1;
      error_count <= error_count + bad;
    end
  end

endmodule

/* tests/reg_array_tb.sv */
module reg_array_tb import rv_types_pkg::*, csr_pkg::*; ();

  localparam int wait_limit = 20; // cycles allowed for the checker to catch up

  logic       clk = 1'b0;
  logic       reset;
  gpr_idx_t   rs1;
  gpr_idx_t   rs2;
  csr_idx_t   csr_rs;
  gpr_write_t gpr_wr;
  csr_write_t csr_wr;
  logic       ecall;
  word_t      rsa;
  word_t      rsb;
  word_t      csra;

  int check_count;
  int error_count;
  int cycles_run;
  int errors_seen;
  int tests_run;
  int tests_failed;
  int timeouts;

  always #50 clk = ~clk;

  reg_array DUT (
    .clk    (clk),
    .reset  (reset),
    .rs1    (rs1),
    .rs2    (rs2),
    .csr_rs (csr_rs),
    .gpr_wr (gpr_wr),
    .csr_wr (csr_wr),
    .ecall  (ecall),
    .rsa    (rsa),
    .rsb    (rsb),
    .csra   (csra)
  );

  reg_array_checker chk (
    .clk         (clk),
    .reset       (reset),
    .rs1         (rs1),
    .rs2         (rs2),
    .csr_rs      (csr_rs),
    .gpr_wr      (gpr_wr),
    .csr_wr      (csr_wr),
    .ecall       (ecall),
    .rsa         (rsa),
    .rsb         (rsb),
    .csra        (csra),
    .check_count (check_count),
    .error_count (error_count)
  );

  function automatic gpr_write_t make_gpr_write(input logic en, input gpr_idx_t idx,
                                                input word_t data);
    gpr_write_t w;
    w.en = en;
    w.idx = idx;
    w.data = data;
    return w;
  endfunction

  function automatic csr_write_t make_csr_write(input logic en, input csr_idx_t idx,
                                                input word_t data);
    csr_write_t w;
    w.en = en;
    w.idx = idx;
    w.data = data;
    return w;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    cycles_run++;
  endtask

  task automatic idle_writes();
    gpr_wr <= make_gpr_write(1'b0, '0, '0);
    csr_wr <= make_csr_write(1'b0, csr_mcause, '0);
    ecall <= 1'b0;
  endtask

  // the checker compares once per cycle, so its count must reach the cycles driven
  task automatic end_test(input string name);
    int waited;
    int errors_now;
    logic late;
    waited = 0;
    while ((check_count < cycles_run) && (waited < wait_limit)) begin
      next_cycle();
      waited++;
    end
    late = (check_count < cycles_run);
    if (late) begin
      $display("test %s: the checker stopped comparing, gave up after %0d cycles",
               name, wait_limit);
      timeouts++;
    end
    errors_now = error_count - errors_seen;
    errors_seen = error_count;
    tests_run++;
    if ((errors_now != 0) || late) begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, errors_now);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset_values();
    for (int i = 0; i < gpr_count; i++) begin
      rs1 <= gpr_idx_t'(i);
      rs2 <= gpr_idx_t'(gpr_count - 1 - i);
      csr_rs <= csr_idx_t'(i[1:0]);
      next_cycle();
    end
    end_test("reset values");
  endtask

  task automatic test_gpr_readback();
    word_t rnd;
    for (int i = 1; i < gpr_count; i++) begin
      rnd = $urandom;
      gpr_wr <= make_gpr_write(1'b1, gpr_idx_t'(i), rnd);
      rs1 <= gpr_idx_t'(i); // still the old value in the write cycle
      rs2 <= gpr_idx_t'(i);
      next_cycle();
      idle_writes();
      next_cycle();
    end
    end_test("gpr readback");
  endtask

  task automatic test_x0_dropped();
    repeat (4) begin
      gpr_wr <= make_gpr_write(1'b1, '0, $urandom);
      rs1 <= '0;
      rs2 <= '0;
      next_cycle();
    end
    idle_writes();
    next_cycle();
    end_test("x0 writes dropped");
  endtask

  task automatic test_csr_readback();
    word_t rnd;
    for (int c = 0; c < csr_count; c++) begin
      rnd = $urandom;
      csr_wr <= make_csr_write(1'b1, csr_idx_t'(c[1:0]), rnd);
      csr_rs <= csr_idx_t'(c[1:0]);
      next_cycle();
      idle_writes();
      next_cycle();
    end
    end_test("csr readback");
  endtask

  task automatic test_ecall_priority();
    gpr_wr <= make_gpr_write(1'b1, ecall_arg_idx, $urandom);
    next_cycle();
    gpr_wr <= make_gpr_write(1'b0, '0, '0);
    ecall <= 1'b1;
    csr_wr <= make_csr_write(1'b1, csr_mcause, $urandom); // loses against ecall
    csr_rs <= csr_mcause;
    next_cycle();
    // x17 changes in this cycle too, mcause must take the stored value
    gpr_wr <= make_gpr_write(1'b1, ecall_arg_idx, $urandom);
    csr_wr <= make_csr_write(1'b1, csr_mepc, $urandom);
    next_cycle();
    idle_writes();
    csr_rs <= csr_mepc;
    rs1 <= ecall_arg_idx;
    next_cycle();
    csr_rs <= csr_mcause;
    next_cycle();
    end_test("ecall priority");
  endtask

  task automatic test_random_mix();
    word_t rnd;
    for (int n = 0; n < 500; n++) begin
      rnd = $urandom;
      rs1 <= gpr_idx_t'(rnd[4:0]);
      rs2 <= gpr_idx_t'(rnd[9:5]);
      csr_rs <= csr_idx_t'(rnd[11:10]);
      ecall <= (rnd[15:13] == 3'd0); // about one cycle in eight
      gpr_wr <= make_gpr_write(rnd[16], gpr_idx_t'(rnd[21:17]), $urandom);
      csr_wr <= make_csr_write(rnd[23:22] == 2'd0, csr_idx_t'(rnd[25:24]), $urandom);
      next_cycle();
    end
    idle_writes();
    next_cycle();
    end_test("random mix");
  endtask

  initial begin
    void'($urandom(59314));
    reset <= 1'b1;
    rs1 <= '0;
    rs2 <= '0;
    csr_rs <= csr_mcause;
    idle_writes();
    cycles_run = 0;
    errors_seen = 0;
    tests_run = 0;
    tests_failed = 0;
    timeouts = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    test_reset_values();
    test_gpr_readback();
    test_x0_dropped();
    test_csr_readback();
    test_ecall_priority();
    test_random_mix();

    $display("summary: %0d tests, %0d failed, %0d cycles compared, %0d mismatches, %0d timeouts",
             tests_run, tests_failed, check_count, error_count, timeouts);
    if ((tests_failed == 0) && (error_count == 0) && (timeouts == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
